// File: logic/ctrl_gen.sv
`timescale 1ns/1ps

module ctrl_gen import z80_cu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  instr_t     q_instr,
	input  logic       q_valid,
	input  logic       ctrl_ready,
	output logic       pop,
	output ctrl_word_t ctrl,
	output logic       ctrl_valid
);

	ctrl_word_t next_word;

	// Bits 5:3 of both ALU groups
	function automatic alu_op_t alu_of_op(logic [2:0] op);
		case (op)
			3'd0:    return ALU_ADD;
			3'd1:    return ALU_ADC;
			3'd2:    return ALU_SUB;
			3'd3:    return ALU_SBC;
			3'd4:    return ALU_AND;
			3'd5:    return ALU_XOR;
			3'd6:    return ALU_OR;
			default: return ALU_CP;
		endcase
	endfunction

	function automatic ctrl_word_t decode(instr_t ins);
		ctrl_word_t w;
		reg_field_t dst;
		reg_field_t src;
		w   = CTRL_IDLE;
		dst = ins.opcode[5:3];
		src = ins.opcode[2:0];
		case (ins.opcode[7:6])
			2'b00:
			begin
				if (ins.has_imm)
				begin
					w.db_sel = DB_CU;	// LD r,n
					w.we     = we_of_field(dst);
					w.cu_out = ins.imm;
				end
				else if ((src == 3'b100 || src == 3'b101) && dst != REG_HL)
				begin
					w.rf_read = 1'b1;	// INC r, DEC r
					w.alu_sel = src[0] ? ALU_DEC : ALU_INC;
					w.re      = re_of_field(dst);
					w.r_sel   = r_sel_of_field(dst);
				end
				else if (src == 3'b111)
				begin
					case (dst)
						3'b101:  w.alu_sel = ALU_CPL;
						3'b110:  w.alu_sel = ALU_SCF;
						3'b111:  w.alu_sel = ALU_CCF;
						default: w.alu_sel = ALU_PASS;	// Rotates, DAA
					endcase
				end
			end
			2'b01:
			begin
				if (dst != REG_HL && src != REG_HL)
				begin
					w.rf_read = 1'b1;	// LD r,r'
					w.re      = re_of_field(src);
					w.we      = we_of_field(dst);
				end
			end
			2'b10:
			begin
				if (src != REG_HL)
				begin
					w.rf_read = 1'b1;	// ALU A,r
					w.alu_sel = alu_of_op(dst);
					w.re      = re_of_field(src);
				end
			end
			default:
			begin
				if (ins.has_imm)
				begin
					w.alu_sel = alu_of_op(dst);	// ALU A,n
					w.db_sel  = DB_CU;
					w.cu_out  = ins.imm;
				end
			end
		endcase
		return w;
	endfunction

	assign next_word = decode(q_instr);

	// Refill when the output register is empty or draining
	assign pop = q_valid && (!ctrl_valid || ctrl_ready);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ctrl       <= CTRL_IDLE;
			ctrl_valid <= 1'b0;
		end
		else if (pop)
		begin
			ctrl       <= next_word;
			ctrl_valid <= 1'b1;
		end
		else if (ctrl_ready)
		begin
			ctrl_valid <= 1'b0;	// Word taken, nothing behind it
		end
	end

	a_hold_stall: assert property (@(posedge clk) disable iff (reset)
		ctrl_valid && !ctrl_ready |=> ctrl_valid && $stable(ctrl))
		else $error("control word changed while stalled");

endmodule

// File: logic/instr_queue.sv
`timescale 1ns/1ps

module instr_queue import z80_cu_pkg::*;
#(
	parameter int DEPTH = 4
)
(
	input  logic   clk,
	input  logic   reset,
	input  logic   push,
	input  instr_t push_instr,
	input  logic   pop,
	output logic   full,
	output instr_t q_instr,
	output logic   q_valid
);

	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] CAP    = (AW + 1)'(DEPTH);
	localparam logic [AW:0] CAP_M1 = (AW + 1)'(DEPTH - 1);

	instr_t          mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [AW:0]     count;

	assign q_instr = mem[rd_ptr];	// Show-ahead head
	assign q_valid = count != '0;

	// Counts the entry landing this edge, since the fetcher
	// registers its push one cycle behind the byte
	assign full = count == CAP || (count == CAP_M1 && push);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at power of two
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_instr;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		push |-> count != CAP)
		else $error("push into full queue");

	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		pop |-> count != '0)
		else $error("pop from empty queue");

endmodule

// File: logic/opcode_fetch.sv
`timescale 1ns/1ps

module opcode_fetch import z80_cu_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  opcode_t in_byte,
	input  logic    in_valid,
	input  logic    full,
	output logic    in_ready,
	output logic    push,
	output instr_t  push_instr,
	output logic    halted
);

	fetch_state_t state;
	logic         running;	// Low until first edge after reset
	opcode_t      pend_op;	// Opcode waiting for its immediate
	logic         take;
	logic         op_has_imm;
	logic         last_byte;
	instr_t       next_instr;

	// LD r,n is 00rrr110 and ALU A,n is 11ooo110
	function automatic logic needs_imm(opcode_t op);
		logic ld_n;
		logic alu_n;
		ld_n  = op[7:6] == 2'b00 && op[2:0] == 3'b110 && op[5:3] != REG_HL;
		alu_n = op[7:6] == 2'b11 && op[2:0] == 3'b110;
		return ld_n || alu_n;
	endfunction

	assign in_ready   = running && state != HALTED && !full;
	assign take       = in_valid && in_ready;
	assign halted     = state == HALTED;
	assign op_has_imm = needs_imm(in_byte);

	always_comb
	begin
		last_byte  = 1'b0;
		next_instr = '{opcode: in_byte, imm: 8'h00, has_imm: 1'b0};
		if (take)
		begin
			case (state)
				FETCH_OP:
				begin
					last_byte = in_byte != OP_HALT && !op_has_imm;
				end
				FETCH_IMM:
				begin
					last_byte  = 1'b1;
					next_instr = '{opcode: pend_op, imm: in_byte, has_imm: 1'b1};
				end
				default:
				begin
					last_byte = 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= FETCH_OP;
			running <= 1'b0;
			push    <= 1'b0;
		end
		else
		begin
			running <= 1'b1;
			push    <= last_byte;
			if (take)
			begin
				case (state)
					FETCH_OP:
					begin
						if (in_byte == OP_HALT)
							state <= HALTED;	// Left only by reset
						else if (op_has_imm)
							state <= FETCH_IMM;
					end
					FETCH_IMM:
					begin
						state <= FETCH_OP;
					end
					default:
					begin
						state <= HALTED;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (take && state == FETCH_OP)
			pend_op <= in_byte;
		if (last_byte)
			push_instr <= next_instr;
	end

	// Once halted, nothing more enters or leaves the fetcher
	a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
		halted |=> halted && !(in_valid && in_ready) && !push)
		else $error("fetcher active after HALT");

endmodule

// File: logic/z80_cu.sv
`timescale 1ns/1ps

module z80_cu import z80_cu_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic       clk,
	input  logic       reset,
	input  opcode_t    in_byte,
	input  logic       in_valid,
	input  logic       ctrl_ready,
	output logic       in_ready,
	output logic       halted,
	output ctrl_word_t ctrl,
	output logic       ctrl_valid
);

	logic   push;
	instr_t push_instr;
	logic   full;
	instr_t q_instr;
	logic   q_valid;
	logic   pop;

	opcode_fetch i_fetch (
		.clk        (clk),
		.reset      (reset),
		.in_byte    (in_byte),
		.in_valid   (in_valid),
		.full       (full),
		.in_ready   (in_ready),
		.push       (push),
		.push_instr (push_instr),
		.halted     (halted)
	);

	instr_queue #(
		.DEPTH (QUEUE_DEPTH)
	) i_queue (
		.clk        (clk),
		.reset      (reset),
		.push       (push),
		.push_instr (push_instr),
		.pop        (pop),
		.full       (full),
		.q_instr    (q_instr),
		.q_valid    (q_valid)
	);

	ctrl_gen i_gen (
		.clk        (clk),
		.reset      (reset),
		.q_instr    (q_instr),
		.q_valid    (q_valid),
		.ctrl_ready (ctrl_ready),
		.pop        (pop),
		.ctrl       (ctrl),
		.ctrl_valid (ctrl_valid)
	);

endmodule

// File: logic/z80_cu_pkg.sv
package z80_cu_pkg;

	typedef logic [7:0]  opcode_t;
	typedef logic [2:0]  reg_field_t;	// B C D E H L (HL) A
	typedef logic [3:0]  rf_re_t;
	typedef logic [15:0] rf_we_t;	// One-hot, A at bit 2
	typedef logic [7:0]  r_sel_t;	// One-hot, A at bit 0

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SBC  = 4'd2,
		ALU_ADC  = 4'd3,
		ALU_AND  = 4'd4,
		ALU_OR   = 4'd5,
		ALU_XOR  = 4'd6,
		ALU_CP   = 4'd7,
		ALU_INC  = 4'd8,
		ALU_DEC  = 4'd9,
		ALU_CPL  = 4'd10,
		ALU_CCF  = 4'd12,
		ALU_SCF  = 4'd13,
		ALU_PASS = 4'd15
	} alu_op_t;

	typedef enum logic [3:0] {
		DB_RF = 4'd0,	// Register file drives the bus
		DB_CU = 4'd1	// Immediate from the decoder
	} db_sel_t;

	typedef enum logic [1:0] {
		FETCH_OP,
		FETCH_IMM,
		HALTED
	} fetch_state_t;

	typedef struct packed {
		opcode_t opcode;
		opcode_t imm;
		logic    has_imm;
	} instr_t;

	typedef struct packed {
		logic    rf_read;
		alu_op_t alu_sel;
		db_sel_t db_sel;
		rf_re_t  re;
		rf_we_t  we;
		r_sel_t  r_sel;
		opcode_t cu_out;
	} ctrl_word_t;

	localparam reg_field_t REG_B  = 3'd0;
	localparam reg_field_t REG_C  = 3'd1;
	localparam reg_field_t REG_D  = 3'd2;
	localparam reg_field_t REG_E  = 3'd3;
	localparam reg_field_t REG_H  = 3'd4;
	localparam reg_field_t REG_L  = 3'd5;
	localparam reg_field_t REG_HL = 3'd6;	// Memory operand, not decoded
	localparam reg_field_t REG_A  = 3'd7;

	localparam opcode_t OP_HALT = 8'h76;

	localparam ctrl_word_t CTRL_IDLE = '{
		rf_read: 1'b0,
		alu_sel: ALU_PASS,
		db_sel:  DB_RF,
		re:      4'd0,
		we:      16'h0000,
		r_sel:   8'h00,
		cu_out:  8'h00
	};

	function automatic rf_re_t re_of_field(reg_field_t f);
		case (f)
			REG_B:   return 4'd2;
			REG_C:   return 4'd3;
			REG_D:   return 4'd4;
			REG_E:   return 4'd5;
			REG_H:   return 4'd6;
			REG_L:   return 4'd7;
			default: return 4'd0;	// A, also (HL)
		endcase
	endfunction

	// B..L sit in a contiguous run above A in both one-hot maps
	function automatic rf_we_t we_of_field(reg_field_t f);
		rf_we_t we;
		we = '0;
		if (f == REG_A)
			we[2] = 1'b1;
		else if (f != REG_HL)
			we[f + 4'd4] = 1'b1;
		return we;
	endfunction

	function automatic r_sel_t r_sel_of_field(reg_field_t f);
		r_sel_t sel;
		sel = '0;
		if (f == REG_A)
			sel[0] = 1'b1;
		else if (f != REG_HL)
			sel[f + 3'd1] = 1'b1;
		return sel;
	endfunction

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_z80_cu -f z80_cu.f > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_z80_cu > sim.log 2>&1

grep -q "TB PASSED" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// File: testbench/tb_z80_cu.sv
`timescale 1ns/1ps

module tb_z80_cu
	import z80_cu_pkg::*;
();

	localparam int TIMEOUT = 200;
	// Per register field B C D E H L (HL) A, element 0 is B
	localparam logic [7:0][3:0] RE_CODE = {4'd0, 4'd0, 4'd7, 4'd6, 4'd5, 4'd4, 4'd3, 4'd2};
	localparam logic [7:0][3:0] WE_BIT  = {4'd2, 4'd0, 4'd9, 4'd8, 4'd7, 4'd6, 4'd5, 4'd4};
	localparam logic [7:0][2:0] SEL_BIT = {3'd0, 3'd0, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1};
	// ADD ADC SUB SBC AND XOR OR CP by bits 5:3
	localparam logic [7:0][3:0] ALU_MAP = {4'd7, 4'd5, 4'd6, 4'd4, 4'd2, 4'd1, 4'd3, 4'd0};

	logic       clk = 1'b0;
	logic       reset;
	opcode_t    in_byte;
	logic       in_valid;
	logic       ctrl_ready;
	logic       in_ready;
	logic       halted;
	ctrl_word_t ctrl;
	logic       ctrl_valid;
	int         cycle = 0;
	int         errors = 0;
	int         tests = 0;
	int         err_mark;
	int         take_cycle;
	int         valid_cycle;
	opcode_t    tx_q[$];	// Bytes still to send
	ctrl_word_t exp_q[$];	// Words still expected

	z80_cu #(
		.QUEUE_DEPTH (4)
	) i_dut (
		.clk        (clk),
		.reset      (reset),
		.in_byte    (in_byte),
		.in_valid   (in_valid),
		.ctrl_ready (ctrl_ready),
		.in_ready   (in_ready),
		.halted     (halted),
		.ctrl       (ctrl),
		.ctrl_valid (ctrl_valid)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic ctrl_word_t model(opcode_t op, opcode_t imm);
		ctrl_word_t w;
		reg_field_t d;
		reg_field_t s;
		logic       ld_rr;
		logic       ld_n;
		logic       incdec;
		logic       alu_r;
		logic       alu_n;
		w = '{rf_read: 1'b0, alu_sel: ALU_PASS, db_sel: DB_RF, re: '0, we: '0, r_sel: '0,
			cu_out: '0};
		d = op[5:3];
		s = op[2:0];
		ld_rr  = op[7:6] == 2'b01 && d != 3'd6 && s != 3'd6;
		ld_n   = op[7:6] == 2'b00 && s == 3'd6 && d != 3'd6;
		incdec = op[7:6] == 2'b00 && (s == 3'd4 || s == 3'd5) && d != 3'd6;
		alu_r  = op[7:6] == 2'b10 && s != 3'd6;
		alu_n  = op[7:6] == 2'b11 && s == 3'd6;
		w.rf_read = ld_rr || incdec || alu_r;
		if (ld_rr || alu_r)
			w.re = RE_CODE[s];	// Source register
		if (incdec)
			w.re = RE_CODE[d];
		if (ld_rr || ld_n)
			w.we[WE_BIT[d]] = 1'b1;
		if (incdec)
			w.r_sel[SEL_BIT[d]] = 1'b1;
		if (incdec)
			w.alu_sel = s == 3'd5 ? ALU_DEC : ALU_INC;	// 00rrr101 is DEC
		if (alu_r || alu_n)
			w.alu_sel = alu_op_t'(ALU_MAP[d]);
		if (ld_n || alu_n)
			w.db_sel = DB_CU;
		if (ld_n || alu_n)
			w.cu_out = imm;
		if (op == 8'h2F)
			w.alu_sel = ALU_CPL;
		if (op == 8'h37)
			w.alu_sel = ALU_SCF;
		if (op == 8'h3F)
			w.alu_sel = ALU_CCF;
		return w;
	endfunction

	function automatic reg_field_t pick_reg();
		reg_field_t f;
		f = 3'($urandom_range(0, 6));
		return f == 3'd6 ? 3'd7 : f;	// Skip (HL)
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		errors++;
		$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
	endtask

	task automatic abort_run(input string why);
		$display("%s at %0t", why, $time);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic add_instr(input opcode_t op, input opcode_t imm, input bit two_byte);
		tx_q.push_back(op);
		if (two_byte)
			tx_q.push_back(imm);
		exp_q.push_back(model(op, imm));
	endtask

	task automatic send_all();
		int waited;
		while (tx_q.size() > 0)
		begin
			in_byte  = tx_q.pop_front();
			in_valid = 1'b1;
			waited   = 0;
			while (!in_ready)
			begin
				@(posedge clk);
				#1;
				waited++;
				if (waited > TIMEOUT)
					abort_run("timeout waiting for in_ready");
			end
			take_cycle = cycle;	// Cycle in which the byte is taken
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic recv_words(input bit random_bp);
		int waited;
		int stall;
		stall  = random_bp ? 12 : 0;	// Long enough to fill the queue
		waited = 0;
		while (exp_q.size() > 0)
		begin
			if (stall > 0)
				ctrl_ready = 1'b0;
			else
				ctrl_ready = random_bp ? 1'($urandom_range(0, 1)) : 1'b1;
			if (ctrl_valid && ctrl_ready)
			begin
				valid_cycle = cycle;
				if (ctrl !== exp_q[0])
					report_mismatch("ctrl", 64'(exp_q[0]), 64'(ctrl));
				void'(exp_q.pop_front());
				waited = 0;
			end
			stall--;
			@(posedge clk);
			#1;
			waited++;
			if (waited > TIMEOUT)
				abort_run("timeout waiting for ctrl_valid");
		end
		ctrl_ready = 1'b1;
	endtask

	task automatic run_stream(input bit random_bp);
		fork
			send_all();
			recv_words(random_bp);
		join
	endtask

	task automatic end_test(input string name);
		repeat (3)
		begin
			if (ctrl_valid)
			begin
				errors++;
				$display("unexpected extra control word after %s at %0t", name, $time);
			end
			@(posedge clk);
			#1;
		end
		tests++;
		$display("%s: %s", name, errors == err_mark ? "ok" : "mismatch");
	endtask

	task automatic reset_and_check();
		reset      = 1'b1;
		in_valid   = 1'b0;
		in_byte    = 8'h00;
		ctrl_ready = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		if (in_ready !== 1'b0)
			report_mismatch("in_ready", 64'd0, 64'(in_ready));
		if (ctrl_valid !== 1'b0)
			report_mismatch("ctrl_valid", 64'd0, 64'(ctrl_valid));
		if (halted !== 1'b0)
			report_mismatch("halted", 64'd0, 64'(halted));
		if (ctrl !== model(8'h00, 8'h00))
			report_mismatch("ctrl", 64'(model(8'h00, 8'h00)), 64'(ctrl));
		@(posedge clk);
		#1;
		if (in_ready !== 1'b1)
			report_mismatch("in_ready", 64'd1, 64'(in_ready));
		ctrl_ready = 1'b1;
	endtask

	task automatic test_reset();
		err_mark = errors;
		reset_and_check();
		end_test("reset");
	endtask

	task automatic test_alu_reg();
		err_mark = errors;
		for (int op = 0; op < 8; op++)
			for (int r = 0; r < 8; r++)
				if (r != 6)
					add_instr({2'b10, op[2:0], r[2:0]}, 8'h00, 1'b0);
		add_instr(8'h2F, 8'h00, 1'b0);	// CPL SCF CCF NOP
		add_instr(8'h37, 8'h00, 1'b0);
		add_instr(8'h3F, 8'h00, 1'b0);
		add_instr(8'h00, 8'h00, 1'b0);
		run_stream(1'b0);
		end_test("alu_reg_and_flags");
	endtask

	task automatic test_immediates();
		err_mark = errors;
		for (int op = 0; op < 8; op++)
			add_instr({2'b11, op[2:0], 3'b110}, 8'($urandom), 1'b1);
		for (int r = 0; r < 8; r++)
			if (r != 6)
				add_instr({2'b00, r[2:0], 3'b110}, 8'($urandom), 1'b1);
		run_stream(1'b0);
		end_test("immediates");
	endtask

	task automatic test_loads_incdec();
		err_mark = errors;
		for (int d = 0; d < 8; d++)
			for (int s = 0; s < 8; s++)
				if (d != 6 && s != 6)
					add_instr({2'b01, d[2:0], s[2:0]}, 8'h00, 1'b0);
		for (int r = 0; r < 8; r++)
			if (r != 6)
			begin
				add_instr({2'b00, r[2:0], 3'b100}, 8'h00, 1'b0);
				add_instr({2'b00, r[2:0], 3'b101}, 8'h00, 1'b0);
			end
		run_stream(1'b0);
		add_instr(8'h3C, 8'h00, 1'b0);	// Lone INC A into an empty pipeline
		run_stream(1'b0);
		if (valid_cycle - take_cycle != 3)
			report_mismatch("ctrl_valid latency", 64'd3, 64'(valid_cycle - take_cycle));
		end_test("loads_incdec_latency");
	endtask

	task automatic test_backpressure();
		reg_field_t d;
		reg_field_t s;
		err_mark = errors;
		for (int i = 0; i < 40; i++)
		begin
			d = pick_reg();
			s = pick_reg();
			case ($urandom_range(0, 3))
				0:       add_instr({2'b01, d, s}, 8'h00, 1'b0);
				1:       add_instr({2'b10, d, s}, 8'h00, 1'b0);
				2:       add_instr({2'b00, d, 3'b110}, 8'($urandom), 1'b1);
				default: add_instr({2'b11, d, 3'b110}, 8'($urandom), 1'b1);
			endcase
		end
		run_stream(1'b1);
		end_test("backpressure");
	endtask

	task automatic test_halt();
		err_mark = errors;
		add_instr(8'hC6, 8'($urandom), 1'b1);
		add_instr(8'h41, 8'h00, 1'b0);
		add_instr(8'h2F, 8'h00, 1'b0);
		tx_q.push_back(8'h76);	// HALT gives no word
		run_stream(1'b0);
		in_byte  = 8'h00;
		in_valid = 1'b1;
		repeat (5)
		begin
			if (ctrl_valid !== 1'b0)
				report_mismatch("ctrl_valid", 64'd0, 64'(ctrl_valid));
			@(posedge clk);
			#1;
			if (halted !== 1'b1)
				report_mismatch("halted", 64'd1, 64'(halted));
			if (in_ready !== 1'b0)
				report_mismatch("in_ready", 64'd0, 64'(in_ready));
		end
		in_valid = 1'b0;
		reset_and_check();
		end_test("halt");
	endtask

	initial
	begin
		void'($urandom(81));
		reset      = 1'b1;
		in_byte    = 8'h00;
		in_valid   = 1'b0;
		ctrl_ready = 1'b0;
		test_reset();
		test_alu_reg();
		test_immediates();
		test_loads_incdec();
		test_backpressure();
		test_halt();
		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: z80_cu.f
logic/z80_cu_pkg.sv
logic/opcode_fetch.sv
logic/instr_queue.sv
logic/ctrl_gen.sv
logic/z80_cu.sv
testbench/tb_z80_cu.sv
